//--- logic/alu_exec_pkg.sv
/* widths, in-flight id count, vector types, operation enums and packed
   bundles shared by the ALU execution subsystem. */
`default_nettype none

package alu_exec_pkg;

    localparam int xlen = 32;               // operand and result width.
    localparam int max_inflight_count = 4;  // ids that can be in flight at once.
    localparam int id_width = 2;            // log2 of the in-flight count.
    localparam int shamt_width = 5;         // shift amount bits taken from rs2.

    typedef logic [xlen-1:0] data_t;                     // operand or result.
    typedef logic [xlen:0] ext_data_t;                   // extended for the carry chain.
    typedef logic [id_width-1:0] inst_id_t;              // instruction id.
    typedef logic [max_inflight_count-1:0] id_mask_t;    // one bit per id.

    // issued functions, encodings match the stimulus op codes.
    typedef enum logic [3:0] {
        alu_op_add  = 4'd0,
        alu_op_sub  = 4'd1,
        alu_op_slt  = 4'd2,
        alu_op_sltu = 4'd3,
        alu_op_xor  = 4'd4,
        alu_op_or   = 4'd5,
        alu_op_and  = 4'd6,
        alu_op_sll  = 4'd7,
        alu_op_srl  = 4'd8,
        alu_op_sra  = 4'd9
    } alu_issue_op_t;

    typedef enum logic [1:0] {
        alu_logic_xor = 2'b00,
        alu_logic_or  = 2'b01,
        alu_logic_and = 2'b10,
        alu_logic_add = 2'b11   // plain add or subtract.
    } alu_logic_op_t;

    typedef enum logic [1:0] {
        alu_add_sub = 2'b00,
        alu_slt     = 2'b01,
        alu_rshift  = 2'b10,
        alu_lshift  = 2'b11
    } alu_result_op_t;

    typedef struct packed {
        alu_issue_op_t op;
        data_t rs1;
        data_t rs2;
    } alu_issue_t;

    typedef struct packed {
        ext_data_t in1;           // rs1, extended.
        ext_data_t in2;           // rs2, extended.
        data_t shifter_in;
        logic subtract;
        logic arith;              // sign fill on right shifts.
        logic lshift;
        alu_logic_op_t logic_op;
        alu_result_op_t op;       // result mux select.
    } alu_inputs_t;

    typedef struct packed {
        inst_id_t id;
        data_t rd;
    } alu_wb_t;

endpackage

`default_nettype wire

//--- logic/alu_operand_prep.sv
/* operand preparation: issued function to adder, logic and shifter
   controls with 33-bit extended operands. */
`default_nettype none

module alu_operand_prep (
    input  alu_exec_pkg::alu_issue_t  issue,
    output alu_exec_pkg::alu_inputs_t alu_inputs
);
    import alu_exec_pkg::*;

    logic sign_ext;     // slt compares as signed.

    assign sign_ext = (issue.op == alu_op_slt);

    // bit 32 of in1 - in2 is the less-than flag for both compares.
    assign alu_inputs.in1 = {sign_ext & issue.rs1[xlen-1], issue.rs1};
    assign alu_inputs.in2 = {sign_ext & issue.rs2[xlen-1], issue.rs2};
    assign alu_inputs.shifter_in = issue.rs1;

    always_comb begin
        alu_inputs.subtract = 1'b0;         // default is a plain add.
        alu_inputs.arith = 1'b0;
        alu_inputs.lshift = 1'b0;
        alu_inputs.logic_op = alu_logic_add;
        alu_inputs.op = alu_add_sub;
        case (issue.op)
            alu_op_add: begin
            end
            alu_op_sub: begin
                alu_inputs.subtract = 1'b1;
            end
            alu_op_slt, alu_op_sltu: begin
                alu_inputs.subtract = 1'b1;   // compare by difference.
                alu_inputs.op = alu_slt;
            end
            alu_op_xor: alu_inputs.logic_op = alu_logic_xor;
            alu_op_or:  alu_inputs.logic_op = alu_logic_or;
            alu_op_and: alu_inputs.logic_op = alu_logic_and;
            alu_op_sll: begin
                alu_inputs.lshift = 1'b1;     // shifter reverses the word.
                alu_inputs.op = alu_lshift;
            end
            alu_op_srl: alu_inputs.op = alu_rshift;
            alu_op_sra: begin
                alu_inputs.arith = 1'b1;
                alu_inputs.op = alu_rshift;
            end
            default: begin
            end
        endcase
    end

    // an operation that carries known operands must carry a known function.
    always_comb begin
        if (!$isunknown({issue.rs1, issue.rs2})) begin
            a_op_known: assert final (!$isunknown(issue.op))
                else $error("alu_operand_prep: unknown op with known operands");
        end
    end

endmodule

`default_nettype wire

//--- logic/barrel_shifter.sv
/* logarithmic 32-bit shifter, right logical or arithmetic, with left
   shifts done by reversing the word around the same levels. */
`default_nettype none

module barrel_shifter (
    input  alu_exec_pkg::data_t                      shifter_input,
    input  logic [alu_exec_pkg::shamt_width-1:0]     shift_amount,
    input  logic                                     arith,
    input  logic                                     lshift,
    output alu_exec_pkg::data_t                      shifted_resultr,
    output alu_exec_pkg::data_t                      shifted_resultl
);
    import alu_exec_pkg::*;

    data_t pre_shift;                   // input, reversed for left shifts.
    data_t level [0:shamt_width];       // one entry per stage boundary.
    logic fill;

    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            pre_shift[i] = lshift ? shifter_input[xlen-1-i] : shifter_input[i];
        end
    end

    assign fill = arith & shifter_input[xlen-1];   // sign fill only for sra.
    assign level[0] = pre_shift;

    // stage s moves the word right by 2**s when its amount bit is set.
    for (genvar s = 0; s < shamt_width; s++) begin : g_level
        assign level[s+1] = shift_amount[s] ?
            {{(2**s){fill}}, level[s][xlen-1:2**s]} : level[s];
    end

    assign shifted_resultr = level[shamt_width];

    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            shifted_resultl[i] = level[shamt_width][xlen-1-i];   // undo reversal.
        end
    end

endmodule

`default_nettype wire

//--- logic/alu_unit.sv
/* single-cycle ALU with a shared carry chain for add, sub, compare and logic,
   barrel shifter, result mux, id-indexed result bank and done mask. */
`default_nettype none

module alu_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  alu_exec_pkg::alu_inputs_t   alu_inputs,
    input  logic                        new_request,
    input  alu_exec_pkg::inst_id_t      instruction_id,
    input  alu_exec_pkg::id_mask_t      instruction_id_one_hot,
    input  alu_exec_pkg::inst_id_t      writeback_instruction_id,
    output alu_exec_pkg::id_mask_t      done_next_cycle,
    output alu_exec_pkg::data_t         rd
);
    import alu_exec_pkg::*;

    ext_data_t adder_in1;
    ext_data_t adder_in2;
    logic [xlen+1:0] sum_full;      // carry-in rides in the low bit.
    ext_data_t add_sub_result;
    data_t rshift_result;
    data_t lshift_result;
    data_t result;
    data_t rd_bank [max_inflight_count];

    // logic ops are formed up front and passed through the adder with a zero.
    always_comb begin
        case (alu_inputs.logic_op)
            alu_logic_xor: adder_in1 = alu_inputs.in1 ^ alu_inputs.in2;
            alu_logic_or:  adder_in1 = alu_inputs.in1 | alu_inputs.in2;
            alu_logic_and: adder_in1 = alu_inputs.in1 & alu_inputs.in2;
            alu_logic_add: adder_in1 = alu_inputs.in1;
        endcase
        if (alu_inputs.logic_op == alu_logic_add) begin
            adder_in2 = alu_inputs.in2 ^ {(xlen+1){alu_inputs.subtract}};  // invert for sub.
        end else begin
            adder_in2 = '0;
        end
    end

    // both low bits set on subtract gives the +1 of two's complement.
    assign sum_full = {adder_in1, alu_inputs.subtract} + {adder_in2, alu_inputs.subtract};
    assign add_sub_result = sum_full[xlen+1:1];

    barrel_shifter u_shifter (
        .shifter_input   (alu_inputs.shifter_in),
        .shift_amount    (alu_inputs.in2[shamt_width-1:0]),   // low 5 bits of rs2.
        .arith           (alu_inputs.arith),
        .lshift          (alu_inputs.lshift),
        .shifted_resultr (rshift_result),
        .shifted_resultl (lshift_result)
    );

    always_comb begin
        case (alu_inputs.op)
            alu_add_sub: result = add_sub_result[xlen-1:0];
            alu_slt:     result = {{(xlen-1){1'b0}}, add_sub_result[xlen]};  // borrow out.
            alu_rshift:  result = rshift_result;
            alu_lshift:  result = lshift_result;
        endcase
    end

    // result parks here until its id reaches the head of the queue.
    always_ff @(posedge clk) begin
        if (new_request) begin
            rd_bank[instruction_id] <= result;
        end
    end

    assign rd = rd_bank[writeback_instruction_id];
    assign done_next_cycle = instruction_id_one_hot & {max_inflight_count{new_request}};

    // the one-hot grant must be a single bit naming the same entry as the id.
    a_done_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        new_request |-> done_next_cycle == (id_mask_t'(1) << instruction_id)
    ) else $error("alu_unit: done_next_cycle does not match instruction_id");

endmodule

`default_nettype wire

//--- logic/id_pool.sv
/* instruction id free list, busy mask with lowest-free grant and
   release on writeback. */
`default_nettype none

module id_pool (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    issue_accept,
    input  logic                    release_valid,
    input  alu_exec_pkg::inst_id_t  release_id,
    output logic                    issue_ready,
    output alu_exec_pkg::inst_id_t  free_id,
    output alu_exec_pkg::id_mask_t  free_id_one_hot
);
    import alu_exec_pkg::*;

    id_mask_t busy;
    id_mask_t free_mask;
    id_mask_t grant_mask;
    id_mask_t release_mask;

    assign free_mask = ~busy;
    assign issue_ready = |free_mask;
    assign free_id_one_hot = free_mask & (~free_mask + id_mask_t'(1));  // lowest set bit.

    // scan down so the lowest free id wins.
    always_comb begin
        free_id = '0;
        for (int i = max_inflight_count - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                free_id = inst_id_t'(i);
            end
        end
    end

    assign grant_mask = issue_accept ? free_id_one_hot : '0;
    assign release_mask = release_valid ? (id_mask_t'(1) << release_id) : '0;

    // a grant and a release at one edge touch different ids.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;                                  // all ids free.
        end else begin
            busy <= (busy | grant_mask) & ~release_mask;
        end
    end

    a_release_busy: assert property (
        @(posedge clk) disable iff (!arst_n) release_valid |-> busy[release_id]
    ) else $error("id_pool: id %0d released while free", release_id);

    a_grant_free: assert property (
        @(posedge clk) disable iff (!arst_n) issue_accept |-> issue_ready && !busy[free_id]
    ) else $error("id_pool: issue accepted with no free id");

endmodule

`default_nettype wire

//--- logic/wb_queue.sv
/* in-order queue of completed ids, four entries with a count, driving
   the writeback port from the result bank. */
`default_nettype none

module wb_queue (
    input  logic                    clk,
    input  logic                    arst_n,
    input  alu_exec_pkg::id_mask_t  done_next_cycle,
    input  logic                    wb_hold,
    input  alu_exec_pkg::data_t     rd,
    output alu_exec_pkg::inst_id_t  wb_read_id,
    output logic                    wb_valid,
    output alu_exec_pkg::alu_wb_t   wb,
    output alu_exec_pkg::inst_id_t  pop_id
);
    import alu_exec_pkg::*;

    inst_id_t id_fifo [max_inflight_count];   // depth equals id count.
    inst_id_t head;                           // wraps with the id width.
    inst_id_t tail;
    logic [id_width:0] count;                 // 0 to 4 entries.
    logic push;
    logic pop;
    logic full;
    inst_id_t push_id;

    assign push = |done_next_cycle;
    assign full = (count == (id_width+1)'(max_inflight_count));

    // one-hot to index.
    always_comb begin
        push_id = '0;
        for (int i = 0; i < max_inflight_count; i++) begin
            if (done_next_cycle[i]) begin
                push_id = inst_id_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            id_fifo[tail] <= push_id;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + 1'b1;
            if (pop) head <= head + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;       // both or neither.
            endcase
        end
    end

    // head goes out whenever something is waiting and the sink is not holding.
    assign pop = (count != '0) && !wb_hold;
    assign wb_valid = pop;
    assign wb_read_id = id_fifo[head];        // bank read address.
    assign pop_id = id_fifo[head];
    assign wb.id = id_fifo[head];
    assign wb.rd = rd;

    // ids in the queue are all busy in the pool, so a fifth push cannot come.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> !full
    ) else $error("wb_queue: push while full");

endmodule

`default_nettype wire

//--- logic/alu_exec.sv
/* ALU execution subsystem top, issue accept, operand prep, ALU with
   result bank, id pool and in-order writeback queue. */
`default_nettype none

module alu_exec (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        issue_valid,
    input  alu_exec_pkg::alu_issue_t    issue,
    output logic                        issue_ready,
    output alu_exec_pkg::inst_id_t      issue_id,
    input  logic                        wb_hold,
    output logic                        wb_valid,
    output alu_exec_pkg::alu_wb_t       wb
);
    import alu_exec_pkg::*;

    logic issue_accept;              // valid meets a free id.
    alu_inputs_t alu_inputs;
    id_mask_t free_id_one_hot;
    id_mask_t done_next_cycle;
    data_t bank_rd;
    inst_id_t wb_read_id;
    inst_id_t pop_id;

    assign issue_accept = issue_valid & issue_ready;

    alu_operand_prep u_prep (
        .issue      (issue),
        .alu_inputs (alu_inputs)
    );

    alu_unit u_alu (
        .clk                      (clk),
        .arst_n                   (arst_n),
        .alu_inputs               (alu_inputs),
        .new_request              (issue_accept),
        .instruction_id           (issue_id),
        .instruction_id_one_hot   (free_id_one_hot),
        .writeback_instruction_id (wb_read_id),
        .done_next_cycle          (done_next_cycle),
        .rd                       (bank_rd)
    );

    // a popped id goes straight back to the pool.
    id_pool u_pool (
        .clk             (clk),
        .arst_n          (arst_n),
        .issue_accept    (issue_accept),
        .release_valid   (wb_valid),
        .release_id      (pop_id),
        .issue_ready     (issue_ready),
        .free_id         (issue_id),
        .free_id_one_hot (free_id_one_hot)
    );

    wb_queue u_wbq (
        .clk             (clk),
        .arst_n          (arst_n),
        .done_next_cycle (done_next_cycle),
        .wb_hold         (wb_hold),
        .rd              (bank_rd),
        .wb_read_id      (wb_read_id),
        .wb_valid        (wb_valid),
        .wb              (wb),
        .pop_id          (pop_id)
    );

endmodule

`default_nettype wire

//--- test/alu_exec_checker.sv
/* writeback checker that models the id pool, pairs each accepted issue with
   its expected result, compares ids, data and port timing, keeps per-test counts. */
`default_nettype none

module alu_exec_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    issue_valid,
    input  logic                    issue_ready,
    input  alu_exec_pkg::inst_id_t  issue_id,
    input  logic                    wb_hold,
    input  logic                    wb_valid,
    input  alu_exec_pkg::alu_wb_t   wb,
    input  alu_exec_pkg::data_t     exp_rd,
    input  logic [7:0]              exp_test,
    input  logic                    exp_last,
    output int                      pending,
    output int                      protocol_errors,
    output int                      tests_passed,
    output int                      tests_failed
);
    import alu_exec_pkg::*;

    typedef struct packed {
        inst_id_t id;            // lowest free id at issue.
        data_t rd;
        logic [7:0] test;
        logic last;              // final line of its test.
        logic bad_grant;         // issue_id was wrong at issue.
    } expect_t;

    expect_t expect_q [$];       // oldest unretired issue at the front.
    expect_t head;
    id_mask_t model_busy;        // ids held by unretired issues.
    inst_id_t exp_grant;
    logic exp_ready;
    logic exp_wb_valid;
    logic bad_grant;
    int test_errors;
    int test_ops;

    // lowest id whose busy bit is clear.
    function automatic inst_id_t lowest_free_id(input id_mask_t busy);
        for (int i = 0; i < max_inflight_count; i++) begin
            if (!busy[i]) begin
                return inst_id_t'(i);
            end
        end
        return '0;
    endfunction

    initial begin
        pending = 0;
        protocol_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_errors = 0;
        test_ops = 0;
        model_busy = '0;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            exp_grant = lowest_free_id(model_busy);
            exp_ready = (model_busy != '1);
            exp_wb_valid = (expect_q.size() != 0) && !wb_hold;   // head goes out unless held.
            if (issue_ready !== exp_ready) begin
                $display("Error at %0t: issue_ready = %b, expected %b",
                         $time, issue_ready, exp_ready);
                protocol_errors++;
            end
            if (wb_valid !== exp_wb_valid) begin
                $display("Error at %0t: wb_valid = %b, expected %b",
                         $time, wb_valid, exp_wb_valid);
                protocol_errors++;
            end
            // retire before issue since an issue never writes back in its own cycle.
            if (wb_valid && expect_q.size() != 0) begin
                head = expect_q.pop_front();
                model_busy[head.id] = 1'b0;      // grantable from the next cycle.
                test_ops++;
                if (head.bad_grant) begin
                    test_errors++;
                end
                if (wb.id !== head.id) begin
                    $display("Error at %0t: wb.id = %0d, expected %0d",
                             $time, wb.id, head.id);
                    test_errors++;
                end
                if (wb.rd !== head.rd) begin
                    $display("Error at %0t: wb.rd = %h, expected %h",
                             $time, wb.rd, head.rd);
                    test_errors++;
                end
                if (head.last) begin
                    if (test_errors == 0) begin
                        $display("test %0d: %0d operations, pass", head.test, test_ops);
                        tests_passed++;
                    end else begin
                        $display("test %0d: %0d operations, %0d mismatches, fail",
                                 head.test, test_ops, test_errors);
                        tests_failed++;
                    end
                    test_errors = 0;
                    test_ops = 0;
                end
            end
            if (issue_valid && issue_ready) begin
                bad_grant = (issue_id !== exp_grant);
                if (bad_grant) begin
                    $display("Error at %0t: issue_id = %0d, expected %0d",
                             $time, issue_id, exp_grant);
                end
                model_busy[exp_grant] = 1'b1;
                expect_q.push_back({exp_grant, exp_rd, exp_test, exp_last, bad_grant});
            end
            pending <= expect_q.size();
        end else begin
            model_busy = '0;                     // every id free in reset.
            expect_q.delete();
            pending <= 0;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_alu_exec.sv
/* testbench top with clock and reset, stimulus file reader, issue driver,
   random writeback hold, id exhaustion check, timeout and final report. */
`default_nettype none

module tb_alu_exec;
    import alu_exec_pkg::*;

    localparam int hold_stretch_cycles = 12;     // long enough to fill every id.
    localparam logic [31:0] rng_seed = 32'h3ad6_02fc;

    typedef struct packed {
        logic [7:0] test;
        logic [3:0] op;
        data_t rs1;
        data_t rs2;
        data_t expected;
    } stim_line_t;

    logic clk;
    logic arst_n;
    logic issue_valid;
    alu_issue_t issue;
    logic issue_ready;
    inst_id_t issue_id;
    logic wb_hold;
    logic wb_valid;
    alu_wb_t wb;
    data_t exp_rd;
    logic [7:0] exp_test;
    logic exp_last;
    int pending;
    int protocol_errors;
    int tests_passed;
    int tests_failed;

    stim_line_t stim [$];
    logic [7:0] cur_test;        // selects the wb_hold mode.
    logic stretch;               // hold writeback for the id exhaustion test.
    int stretch_cycles;
    int stretch_accepts;
    int tb_errors;
    int n_tests;
    int cycles;
    int cycle_limit = 100000;    // replaced once the stimulus is loaded.
    logic [31:0] rng;

    always #2 clk = ~clk;

    alu_exec i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .issue_id    (issue_id),
        .wb_hold     (wb_hold),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    alu_exec_checker u_checker (
        .clk             (clk),
        .arst_n          (arst_n),
        .issue_valid     (issue_valid),
        .issue_ready     (issue_ready),
        .issue_id        (issue_id),
        .wb_hold         (wb_hold),
        .wb_valid        (wb_valid),
        .wb              (wb),
        .exp_rd          (exp_rd),
        .exp_test        (exp_test),
        .exp_last        (exp_last),
        .pending         (pending),
        .protocol_errors (protocol_errors),
        .tests_passed    (tests_passed),
        .tests_failed    (tests_failed)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // true when line i closes its test.
    function automatic logic ends_test(input int i);
        return (i == stim.size() - 1) || (stim[i+1].test != stim[i].test);
    endfunction

    function automatic int load_stimulus();
        int fd;
        string line;
        logic [31:0] t;
        logic [31:0] op;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] ex;
        fd = $fopen("test/alu_exec_stim.txt", "r");
        if (fd == 0) begin
            return 0;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %h %h", t, op, rs1, rs2, ex) == 5) begin
                    stim.push_back({t[7:0], op[3:0], rs1, rs2, ex});
                end
            end
        end
        $fclose(fd);
        return 1;
    endfunction

    // random hold in tests 4 and 5 and a solid stretch while ids run out.
    always @(posedge clk) begin
        if (stretch) begin
            wb_hold <= 1'b1;
        end else if (cur_test >= 8'd4) begin
            rng = next_random(rng);
            wb_hold <= rng[0];
        end else begin
            wb_hold <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (stretch) begin
            if (issue_valid && issue_ready) begin
                stretch_accepts++;
            end
            stretch_cycles++;
            if (stretch_cycles == hold_stretch_cycles) begin
                if (stretch_accepts != max_inflight_count || issue_ready) begin
                    $display("id exhaustion: %0d issues accepted under hold, issue_ready %b",
                             stretch_accepts, issue_ready);
                    tb_errors++;
                end
                stretch <= 1'b0;
            end
        end else begin
            stretch_cycles = 0;
            stretch_accepts = 0;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles with operations still outstanding", cycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        wb_hold = 1'b0;
        exp_rd = '0;
        exp_test = '0;
        exp_last = 1'b0;
        cur_test = '0;
        stretch = 1'b0;
        tb_errors = 0;
        n_tests = 0;
        rng = rng_seed;
        if (load_stimulus() == 0) begin
            $display("could not open the stimulus file test/alu_exec_stim.txt");
            $display("sim failed");
            $finish;
        end else begin
            cycle_limit = 10 * stim.size() + 100;
            for (int i = 0; i < stim.size(); i++) begin
                if (ends_test(i)) begin
                    n_tests++;
                end
            end
            repeat (2) @(posedge clk);
            arst_n <= 1'b1;
            for (int i = 0; i < stim.size(); i++) begin
                // test 5 starts from an empty pool.
                if (stim[i].test == 8'd5 && (i == 0 || stim[i-1].test != 8'd5)) begin
                    issue_valid <= 1'b0;
                    @(posedge clk);
                    while (pending != 0) @(posedge clk);
                    stretch <= 1'b1;
                end
                cur_test <= stim[i].test;
                issue_valid <= 1'b1;
                issue <= {stim[i].op, stim[i].rs1, stim[i].rs2};
                exp_rd <= stim[i].expected;
                exp_test <= stim[i].test;
                exp_last <= ends_test(i);
                @(posedge clk);
                while (!issue_ready) @(posedge clk);   // held until accepted.
            end
            issue_valid <= 1'b0;
            @(posedge clk);
            while (pending != 0) @(posedge clk);
            repeat (4) @(posedge clk);
            $display("tests passed %0d, failed %0d, other errors %0d",
                     tests_passed, tests_failed, protocol_errors + tb_errors);
            if (n_tests != 0 && tests_failed == 0 && tests_passed == n_tests &&
                protocol_errors == 0 && tb_errors == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- alu_exec.f
logic/alu_exec_pkg.sv
logic/alu_operand_prep.sv
logic/barrel_shifter.sv
logic/alu_unit.sv
logic/id_pool.sv
logic/wb_queue.sv
logic/alu_exec.sv
test/alu_exec_checker.sv
test/tb_alu_exec.sv

//--- test/alu_exec_stim.txt
# columns: test, op (0 add 1 sub 2 slt 3 sltu 4 xor 5 or 6 and 7 sll 8 srl 9 sra),
# rs1, rs2, expected result; all hex
1 0 00000005 00000007 0000000c
1 0 ffffffff 00000001 00000000
1 0 7fffffff 00000001 80000000
1 1 00000003 00000005 fffffffe
1 1 80000000 00000001 7fffffff
1 4 f0f0f0f0 ff00ff00 0ff00ff0
1 5 f0f0f0f0 0f0f0000 fffff0f0
1 6 12345678 0000ffff 00005678
2 2 00000005 00000005 00000000
2 3 00000005 00000005 00000000
2 2 ffffffff 00000001 00000001
2 3 ffffffff 00000001 00000000
2 2 00000001 ffffffff 00000000
2 3 00000001 ffffffff 00000001
2 2 80000000 7fffffff 00000001
2 3 80000000 7fffffff 00000000
2 2 00000003 00000007 00000001
2 3 00000003 00000007 00000001
3 7 00000001 0000001f 80000000
3 7 12345678 00000000 12345678
3 7 00000003 00000024 00000030
3 8 80000000 0000001f 00000001
3 8 f0000000 00000004 0f000000
3 8 12345678 00000020 12345678
3 9 f0000000 00000004 ff000000
3 9 80000000 0000001f ffffffff
3 9 7fffffff 0000001e 00000001
4 0 00000010 00000020 00000030
4 1 00000100 00000001 000000ff
4 4 aaaaaaaa 55555555 ffffffff
4 7 0000000f 00000008 00000f00
4 2 fffffffe ffffffff 00000001
4 6 ffff0000 0f0f0f0f 0f0f0000
4 9 80000001 00000001 c0000000
5 0 00000001 00000001 00000002
5 0 00000002 00000002 00000004
5 1 0000000a 00000003 00000007
5 8 00000100 00000004 00000010
5 4 0000ffff 00ff00ff 00ffff00
5 3 00000001 00000000 00000000
